// ==== include/shader_consts.svh ====
`ifndef SHADER_CONSTS_SVH
`define SHADER_CONSTS_SVH

// datapath and memory port widths
`define SHADER_WORD_WIDTH 32
`define SHADER_ADDR_WIDTH 16
`define SHADER_REG_ADDR_WIDTH 5

// program counter stepping and start point
`define SHADER_PC_STEP 4
`define SHADER_RESET_PC 0

// system immediate that stops the core (ebreak)
`define SHADER_HALT_IMM 1

`endif

// ==== source/shader_isa_pkg.sv ====
`default_nettype none
`include "shader_consts.svh"

package shader_isa_pkg;

    typedef logic [`SHADER_WORD_WIDTH-1:0] word_t;
    typedef logic [`SHADER_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`SHADER_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_none = 4'd15
    } alu_op_e;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct_e;

endpackage

`default_nettype wire

// ==== source/shader_core_pkg.sv ====
`default_nettype none
`include "shader_consts.svh"

package shader_core_pkg;

    // one state per cycle of the instruction sequence
    typedef enum logic [3:0] {
        st_init,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_registers,
        st_execute,
        st_load,
        st_load_wait,
        st_store,
        st_retire,
        st_halted
    } seq_state_e;

    typedef struct packed {
        shader_isa_pkg::opcode_e   opcode;
        shader_isa_pkg::reg_addr_t rd;
        shader_isa_pkg::reg_addr_t rs1;
        shader_isa_pkg::reg_addr_t rs2;
        logic [2:0]                funct3;
        shader_isa_pkg::alu_op_e   alu_op;
        // already selected for the opcode and sign extended
        shader_isa_pkg::word_t     imm;
    } decoded_t;

    typedef struct packed {
        shader_isa_pkg::word_t value;
        logic                  branch_taken;
    } exec_result_t;

    typedef struct packed {
        logic                      enable;
        shader_isa_pkg::reg_addr_t rd;
        shader_isa_pkg::word_t     value;
    } writeback_t;

endpackage

`default_nettype wire

// ==== source/shader_decode.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "shader_consts.svh"

module shader_decode (
    input  wire logic                      clock,
    input  wire logic                      latch_inst,
    input  wire shader_isa_pkg::word_t     inst_ram_read_result,
    output shader_core_pkg::decoded_t      decoded
);

    shader_isa_pkg::word_t   inst;
    shader_isa_pkg::opcode_e opcode;
    shader_isa_pkg::word_t   imm_i;
    shader_isa_pkg::word_t   imm_s;
    shader_isa_pkg::word_t   imm_b;
    shader_isa_pkg::word_t   imm_u;
    shader_isa_pkg::word_t   imm_j;
    shader_isa_pkg::word_t   imm_shamt;
    shader_isa_pkg::alu_op_e funct3_op;
    logic [2:0]              funct3;
    logic                    is_shift;

    // instruction word held for the rest of the sequence
    always_ff @(posedge clock) begin
        if (latch_inst) begin
            inst <= inst_ram_read_result;
        end
    end

    assign opcode = shader_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_shamt = {{(`SHADER_WORD_WIDTH-5){1'b0}}, inst[24:20]};

    // bit 30 picks sub over add (register form only) and sra over srl
    always_comb begin
        case (funct3)
            3'b000: funct3_op = (opcode == shader_isa_pkg::op_reg && inst[30]) ?
                                shader_isa_pkg::alu_sub : shader_isa_pkg::alu_add;
            3'b001: funct3_op = shader_isa_pkg::alu_sll;
            3'b010: funct3_op = shader_isa_pkg::alu_slt;
            3'b011: funct3_op = shader_isa_pkg::alu_sltu;
            3'b100: funct3_op = shader_isa_pkg::alu_xor;
            3'b101: funct3_op = inst[30] ? shader_isa_pkg::alu_sra : shader_isa_pkg::alu_srl;
            3'b110: funct3_op = shader_isa_pkg::alu_or;
            default: funct3_op = shader_isa_pkg::alu_and;
        endcase
    end

    always_comb begin
        decoded.opcode = opcode;
        decoded.rd = inst[11:7];
        decoded.rs1 = inst[19:15];
        decoded.rs2 = inst[24:20];
        decoded.funct3 = funct3;
        decoded.alu_op = shader_isa_pkg::alu_add;
        decoded.imm = '0;
        case (opcode)
            shader_isa_pkg::op_imm: begin
                decoded.alu_op = funct3_op;
                decoded.imm = is_shift ? imm_shamt : imm_i;
            end
            shader_isa_pkg::op_reg: decoded.alu_op = funct3_op;
            shader_isa_pkg::op_lui: decoded.imm = imm_u;
            shader_isa_pkg::op_jal: decoded.imm = imm_j;
            shader_isa_pkg::op_jalr,
            shader_isa_pkg::op_load,
            shader_isa_pkg::op_system: decoded.imm = imm_i;
            shader_isa_pkg::op_store: decoded.imm = imm_s;
            shader_isa_pkg::op_branch: decoded.imm = imm_b;
            default: decoded.alu_op = shader_isa_pkg::alu_none;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/shader_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "shader_consts.svh"

module shader_regfile (
    input  wire logic                       clock,
    input  wire shader_isa_pkg::reg_addr_t  rs1,
    input  wire shader_isa_pkg::reg_addr_t  rs2,
    input  wire shader_core_pkg::writeback_t writeback,
    output shader_isa_pkg::word_t           rs1_value,
    output shader_isa_pkg::word_t           rs2_value
);

    shader_isa_pkg::word_t bank [2**`SHADER_REG_ADDR_WIDTH];

    always_ff @(posedge clock) begin
        if (writeback.enable && writeback.rd != '0) begin
            bank[writeback.rd] <= writeback.value;
        end
    end

    // x0 reads as zero whatever the bank holds
    assign rs1_value = (rs1 == '0) ? '0 : bank[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : bank[rs2];

    // the sequencer filters rd before it raises the write enable
    no_x0_write: assert property (@(posedge clock)
        writeback.enable |-> writeback.rd != '0);

endmodule

`default_nettype wire

// ==== source/shader_execute.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "shader_consts.svh"

module shader_execute (
    input  wire logic                      clock,
    input  wire logic                      capture,
    input  wire shader_isa_pkg::word_t     pc,
    input  wire shader_core_pkg::decoded_t decoded,
    input  wire shader_isa_pkg::word_t     rs1_value,
    input  wire shader_isa_pkg::word_t     rs2_value,
    output shader_core_pkg::exec_result_t  result
);

    shader_isa_pkg::word_t op1;
    shader_isa_pkg::word_t op2;
    shader_isa_pkg::word_t alu_out;
    logic [4:0]            shamt;
    logic                  is_shift;
    logic                  taken;

    assign is_shift = decoded.alu_op inside
        {shader_isa_pkg::alu_sll, shader_isa_pkg::alu_srl, shader_isa_pkg::alu_sra};
    assign shamt = op2[4:0];

    always_comb begin
        case (decoded.opcode)
            shader_isa_pkg::op_imm,
            shader_isa_pkg::op_reg,
            shader_isa_pkg::op_jalr,
            shader_isa_pkg::op_load,
            shader_isa_pkg::op_store: op1 = rs1_value;
            // jump and branch targets are pc relative
            shader_isa_pkg::op_jal,
            shader_isa_pkg::op_branch: op1 = pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        if (decoded.opcode == shader_isa_pkg::op_reg) begin
            op2 = is_shift ? {{(`SHADER_WORD_WIDTH-5){1'b0}}, rs2_value[4:0]} : rs2_value;
        end else begin
            op2 = decoded.imm;
        end
    end

    always_comb begin
        case (decoded.alu_op)
            shader_isa_pkg::alu_add: alu_out = op1 + op2;
            shader_isa_pkg::alu_sub: alu_out = op1 - op2;
            shader_isa_pkg::alu_sll: alu_out = op1 << shamt;
            shader_isa_pkg::alu_slt: alu_out = shader_isa_pkg::word_t'($signed(op1) < $signed(op2));
            shader_isa_pkg::alu_sltu: alu_out = shader_isa_pkg::word_t'(op1 < op2);
            shader_isa_pkg::alu_xor: alu_out = op1 ^ op2;
            shader_isa_pkg::alu_srl: alu_out = op1 >> shamt;
            shader_isa_pkg::alu_sra: alu_out = shader_isa_pkg::word_t'($signed(op1) >>> shamt);
            shader_isa_pkg::alu_or: alu_out = op1 | op2;
            shader_isa_pkg::alu_and: alu_out = op1 & op2;
            default: alu_out = '0;
        endcase
    end

    // branch condition always compares the two register values
    always_comb begin
        case (shader_isa_pkg::branch_funct_e'(decoded.funct3))
            shader_isa_pkg::beq: taken = rs1_value == rs2_value;
            shader_isa_pkg::bne: taken = rs1_value != rs2_value;
            shader_isa_pkg::blt: taken = $signed(rs1_value) < $signed(rs2_value);
            shader_isa_pkg::bge: taken = $signed(rs1_value) >= $signed(rs2_value);
            shader_isa_pkg::bltu: taken = rs1_value < rs2_value;
            shader_isa_pkg::bgeu: taken = rs1_value >= rs2_value;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            result <= '{value: alu_out, branch_taken: taken};
        end
    end

endmodule

`default_nettype wire

// ==== source/shader_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "shader_consts.svh"

module shader_sequencer (
    input  wire logic                         clock,
    input  wire logic                         reset_n,
    input  wire logic                         run,
    input  wire shader_core_pkg::decoded_t    decoded,
    input  wire shader_core_pkg::exec_result_t result,
    input  wire shader_isa_pkg::word_t        rs2_value,
    input  wire shader_isa_pkg::word_t        data_ram_read_result,
    output logic                              latch_inst,
    output logic                              capture,
    output shader_isa_pkg::word_t             pc,
    output shader_isa_pkg::mem_addr_t         inst_ram_address,
    output shader_isa_pkg::mem_addr_t         data_ram_address,
    output shader_isa_pkg::word_t             data_ram_write_data,
    output logic                              data_ram_write,
    output shader_core_pkg::writeback_t       writeback,
    output logic                              halted
);

    shader_core_pkg::seq_state_e state;
    shader_isa_pkg::word_t       pc_step;
    shader_isa_pkg::reg_addr_t   wb_rd;
    shader_isa_pkg::word_t       wb_value;
    logic                        wb_enable;
    logic                        is_jump;
    logic                        writes_rd;

    assign is_jump = decoded.opcode inside {shader_isa_pkg::op_jal, shader_isa_pkg::op_jalr};
    assign writes_rd = is_jump || decoded.opcode inside {shader_isa_pkg::op_imm,
        shader_isa_pkg::op_reg, shader_isa_pkg::op_lui, shader_isa_pkg::op_load};
    assign pc_step = pc + `SHADER_PC_STEP;

    // stage enables follow the state, and stall with it when run is low
    assign latch_inst = run && state == shader_core_pkg::st_decode;
    assign capture = run && state == shader_core_pkg::st_execute;
    assign writeback = '{enable: wb_enable, rd: wb_rd, value: wb_value};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= shader_core_pkg::st_init;
            pc <= shader_isa_pkg::word_t'(`SHADER_RESET_PC);
            halted <= 1'b0;
            data_ram_write <= 1'b0;
            wb_enable <= 1'b0;
        end else if (run) begin
            case (state)
                shader_core_pkg::st_init: state <= shader_core_pkg::st_fetch;
                shader_core_pkg::st_fetch: begin
                    // last retire's writeback lands in the bank this cycle
                    wb_enable <= 1'b0;
                    state <= shader_core_pkg::st_fetch_wait;
                end
                shader_core_pkg::st_fetch_wait: state <= shader_core_pkg::st_decode;
                shader_core_pkg::st_decode: state <= shader_core_pkg::st_registers;
                shader_core_pkg::st_registers: begin
                    halted <= decoded.opcode == shader_isa_pkg::op_system &&
                              decoded.imm == shader_isa_pkg::word_t'(`SHADER_HALT_IMM);
                    state <= shader_core_pkg::st_execute;
                end
                shader_core_pkg::st_execute: begin
                    if (halted) begin
                        state <= shader_core_pkg::st_halted;
                    end else if (decoded.opcode == shader_isa_pkg::op_load) begin
                        state <= shader_core_pkg::st_load;
                    end else if (decoded.opcode == shader_isa_pkg::op_store) begin
                        state <= shader_core_pkg::st_store;
                    end else begin
                        state <= shader_core_pkg::st_retire;
                    end
                end
                shader_core_pkg::st_load: state <= shader_core_pkg::st_load_wait;
                shader_core_pkg::st_load_wait: state <= shader_core_pkg::st_retire;
                shader_core_pkg::st_store: begin
                    data_ram_write <= 1'b1;
                    state <= shader_core_pkg::st_retire;
                end
                shader_core_pkg::st_retire: begin
                    data_ram_write <= 1'b0;
                    wb_enable <= writes_rd && decoded.rd != '0;
                    if (is_jump) begin
                        pc <= {result.value[`SHADER_WORD_WIDTH-1:1], 1'b0};
                    end else if (decoded.opcode == shader_isa_pkg::op_branch &&
                                 result.branch_taken) begin
                        pc <= result.value;
                    end else begin
                        pc <= pc_step;
                    end
                    state <= shader_core_pkg::st_fetch;
                end
                shader_core_pkg::st_halted: state <= shader_core_pkg::st_halted;
                default: state <= shader_core_pkg::st_init;
            endcase
        end
    end

    // memory addresses, store data and writeback payload
    always_ff @(posedge clock) begin
        if (run) begin
            case (state)
                shader_core_pkg::st_fetch: inst_ram_address <= pc[`SHADER_ADDR_WIDTH-1:0];
                shader_core_pkg::st_load: begin
                    data_ram_address <= result.value[`SHADER_ADDR_WIDTH-1:0];
                end
                shader_core_pkg::st_store: begin
                    data_ram_address <= result.value[`SHADER_ADDR_WIDTH-1:0];
                    data_ram_write_data <= rs2_value;
                end
                shader_core_pkg::st_retire: begin
                    wb_rd <= decoded.rd;
                    if (is_jump) begin
                        wb_value <= pc_step;
                    end else if (decoded.opcode == shader_isa_pkg::op_load) begin
                        wb_value <= data_ram_read_result;
                    end else begin
                        wb_value <= result.value;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // store strobe covers a single retire cycle
    store_pulse_single: assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write && run |=> !data_ram_write);

    // only reset leaves the halted state
    halt_is_final: assert property (@(posedge clock) disable iff (!reset_n)
        state == shader_core_pkg::st_halted |=> state == shader_core_pkg::st_halted);

endmodule

`default_nettype wire

// ==== source/shader_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "shader_consts.svh"

module shader_core (
    input  wire logic                  clock,
    input  wire logic                  reset_n,
    input  wire logic                  run,
    output logic                       halted,
    output shader_isa_pkg::mem_addr_t  inst_ram_address,
    input  wire shader_isa_pkg::word_t inst_ram_read_result,
    output shader_isa_pkg::mem_addr_t  data_ram_address,
    output shader_isa_pkg::word_t      data_ram_write_data,
    output logic                       data_ram_write,
    input  wire shader_isa_pkg::word_t data_ram_read_result
);

    shader_core_pkg::decoded_t     decoded;
    shader_core_pkg::exec_result_t result;
    shader_core_pkg::writeback_t   writeback;
    shader_isa_pkg::word_t         rs1_value;
    shader_isa_pkg::word_t         rs2_value;
    shader_isa_pkg::word_t         pc;
    logic                          latch_inst;
    logic                          capture;

    shader_sequencer i_shader_sequencer (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .decoded(decoded),
        .result(result),
        .rs2_value(rs2_value),
        .data_ram_read_result(data_ram_read_result),
        .latch_inst(latch_inst),
        .capture(capture),
        .pc(pc),
        .inst_ram_address(inst_ram_address),
        .data_ram_address(data_ram_address),
        .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write),
        .writeback(writeback),
        .halted(halted)
    );

    shader_decode i_shader_decode (
        .clock(clock),
        .latch_inst(latch_inst),
        .inst_ram_read_result(inst_ram_read_result),
        .decoded(decoded)
    );

    shader_regfile i_shader_regfile (
        .clock(clock),
        .rs1(decoded.rs1),
        .rs2(decoded.rs2),
        .writeback(writeback),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    shader_execute i_shader_execute (
        .clock(clock),
        .capture(capture),
        .pc(pc),
        .decoded(decoded),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .result(result)
    );

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset_n
);

    // 8 ns period
    initial clock = 1'b0;
    always #4 clock = ~clock;

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/shader_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module shader_core_tb;

    logic        clock;
    logic        reset_n;
    logic        run;
    logic        halted;
    logic [15:0] inst_ram_address;
    logic [31:0] inst_ram_read_result;
    logic [15:0] data_ram_address;
    logic [31:0] data_ram_write_data;
    logic        data_ram_write;
    logic [31:0] data_ram_read_result;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] exp_value [0:63];
    logic [15:0] exp_addr [0:63];
    int          exp_count = 0;
    int          store_count = 0;
    int          pc_emit = 0;
    int          sa = 16;
    int          value_errors = 0;
    int          address_errors = 0;
    int          other_errors = 0;
    logic        seen_edge = 1'b0;

    clock_gen i_clock_gen (.clock(clock), .reset_n(reset_n));

    shader_core i_shader_core (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .halted(halted),
        .inst_ram_address(inst_ram_address),
        .inst_ram_read_result(inst_ram_read_result),
        .data_ram_address(data_ram_address),
        .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write),
        .data_ram_read_result(data_ram_read_result)
    );

    // synchronous memories whose data follows the registered address
    always @(posedge clock) begin
        seen_edge <= 1'b1;
        inst_ram_read_result <= imem[inst_ram_address[9:2]];
        data_ram_read_result <= dmem[data_ram_address[9:2]];
        if (data_ram_write) begin
            dmem[data_ram_address[9:2]] <= data_ram_write_data;
            store_count <= store_count + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2);
        return {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // RV32I integer results where alt is instruction bit 30
    function automatic logic [31:0] ref_alu(input int f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input int f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[pc_emit[9:2]] = word;
        pc_emit = pc_emit + 4;
    endtask

    // sw rs to the next slot and record it only when that path runs
    task automatic store_reg(input int rs, input logic [31:0] value, input logic record);
        emit(enc_s(sa, rs));
        if (record) begin
            exp_value[exp_count] = value;
            exp_addr[exp_count] = sa[15:0];
            exp_count = exp_count + 1;
            sa = sa + 4;
        end
    endtask

    task automatic branch_case(input int f3, input int r1, input int r2,
                               input logic [31:0] v1, input logic [31:0] v2, input int idx);
        logic taken;
        taken = ref_branch(f3, v1, v2);
        emit(enc_b(8, r2, r1, f3));
        emit(enc_j(12, 0));
        emit(enc_i(idx, 0, 0, 4, 7'b0010011));
        store_reg(4, idx, taken);
    endtask

    task automatic build_program(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] imm32;
        int          q;
        int          f3;
        emit(enc_i(0, 0, 2, 1, 7'b0000011));
        emit(enc_i(4, 0, 2, 2, 7'b0000011));
        for (f3 = 0; f3 < 8; f3++) begin
            emit(enc_r(0, 2, 1, f3, 3));
            store_reg(3, ref_alu(f3, 1'b0, a, b), 1'b1);
        end
        emit(enc_r(32, 2, 1, 0, 3));
        store_reg(3, ref_alu(0, 1'b1, a, b), 1'b1);
        emit(enc_r(32, 2, 1, 5, 3));
        store_reg(3, ref_alu(5, 1'b1, a, b), 1'b1);
        imm32 = 32'hfffffda3;
        for (f3 = 0; f3 < 8; f3++) begin
            if (f3 != 1 && f3 != 5) begin
                emit(enc_i(32'hda3, 1, f3, 3, 7'b0010011));
                store_reg(3, ref_alu(f3, 1'b0, a, imm32), 1'b1);
            end
        end
        emit(enc_i(7, 1, 1, 3, 7'b0010011));
        store_reg(3, ref_alu(1, 1'b0, a, 32'd7), 1'b1);
        emit(enc_i(7, 1, 5, 3, 7'b0010011));
        store_reg(3, ref_alu(5, 1'b0, a, 32'd7), 1'b1);
        emit(enc_i(32'h407, 1, 5, 3, 7'b0010011));
        store_reg(3, ref_alu(5, 1'b1, a, 32'd7), 1'b1);
        emit({20'habcde, 5'd3, 7'b0110111});
        store_reg(3, 32'habcde000, 1'b1);
        // x0 must ignore the write
        emit(enc_i(5, 1, 0, 0, 7'b0010011));
        store_reg(0, 32'd0, 1'b1);
        emit(enc_i(32'hffd, 0, 0, 5, 7'b0010011));
        emit(enc_i(5, 0, 0, 6, 7'b0010011));
        branch_case(0, 5, 5, -3, -3, 1);
        branch_case(0, 5, 6, -3, 5, 2);
        branch_case(1, 5, 6, -3, 5, 3);
        branch_case(1, 5, 5, -3, -3, 4);
        branch_case(4, 5, 6, -3, 5, 5);
        branch_case(4, 6, 5, 5, -3, 6);
        branch_case(5, 6, 5, 5, -3, 7);
        branch_case(5, 5, 6, -3, 5, 8);
        branch_case(6, 6, 5, 5, -3, 9);
        branch_case(6, 5, 6, -3, 5, 10);
        branch_case(7, 5, 6, -3, 5, 11);
        branch_case(7, 6, 5, 5, -3, 12);
        // jal over a self loop with the link checked at the target
        q = pc_emit;
        emit(enc_j(8, 7));
        emit(enc_j(0, 0));
        store_reg(7, q + 4, 1'b1);
        // jalr target is odd before bit 0 is cleared
        q = pc_emit;
        emit(enc_i(q + 8, 0, 0, 8, 7'b0010011));
        emit(enc_i(5, 8, 0, 9, 7'b1100111));
        emit(enc_j(0, 0));
        store_reg(9, q + 8, 1'b1);
        emit(32'h00100073);
        store_reg(6, 32'd5, 1'b0);
    endtask

    task automatic report_and_finish();
        $display("errors: value %0d, address %0d, other %0d",
                 value_errors, address_errors, other_errors);
        if (value_errors + address_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    store_in_table: assert property (@(posedge clock)
        data_ram_write |-> store_count < exp_count)
    else begin
        other_errors++;
        $display("store at %0t beyond the %0d expected stores", $time, exp_count);
    end

    store_value: assert property (@(posedge clock)
        data_ram_write && store_count < exp_count |->
        data_ram_write_data == exp_value[store_count])
    else begin
        value_errors++;
        $display("[FAIL] %0t data_ram_write_data got %h expected %h", $time,
                 $sampled(data_ram_write_data), exp_value[$sampled(store_count)]);
    end

    store_address: assert property (@(posedge clock)
        data_ram_write && store_count < exp_count |->
        data_ram_address == exp_addr[store_count])
    else begin
        address_errors++;
        $display("[FAIL] %0t data_ram_address got %h expected %h", $time,
                 $sampled(data_ram_address), exp_addr[$sampled(store_count)]);
    end

    idle_when_stopped: assert property (@(posedge clock)
        seen_edge && (!reset_n || !run) |-> !halted && !data_ram_write)
    else begin
        other_errors++;
        $display("core active at %0t during reset or with run low", $time);
    end

    quiet_after_halt: assert property (@(posedge clock)
        halted |-> !data_ram_write)
    else begin
        other_errors++;
        $display("store at %0t after the core halted", $time);
    end

    initial begin
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        int          i;
        int          cycles;
        run = 1'b0;
        inst_ram_read_result = '0;
        data_ram_read_result = '0;
        for (i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h7f};
            dmem[i] = {16'hd5a7, i[15:0]};
        end
        rnd_a = xorshift(32'h11a8ecc3);
        rnd_b = xorshift(rnd_a);
        dmem[0] = rnd_a;
        dmem[1] = rnd_b;
        build_program(rnd_a, rnd_b);

        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 50) begin
            @(posedge clock);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            other_errors++;
            $display("timeout waiting for reset release");
            report_and_finish();
        end else begin
            repeat (10) @(posedge clock);
            run <= 1'b1;
            cycles = 0;
            while (halted !== 1'b1 && cycles < 5000) begin
                @(posedge clock);
                cycles++;
            end
            if (halted !== 1'b1) begin
                other_errors++;
                $display("timeout waiting for halted");
            end
            repeat (20) @(posedge clock);
            assert (store_count == exp_count)
            else begin
                other_errors++;
                $display("store count %0d, expected %0d", store_count, exp_count);
            end
            report_and_finish();
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/shader_isa_pkg.sv
source/shader_core_pkg.sv
source/shader_decode.sv
source/shader_regfile.sv
source/shader_execute.sv
source/shader_sequencer.sv
source/shader_core.sv
sim/clock_gen.sv
sim/shader_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module shader_core_tb \
    -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vshader_core_tb > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
